// File: Bender.yml
package:
  name: alu_credit

sources:
  - include_dirs:
      - source
    files:
      - source/alu_pkg.sv
      - source/setter.sv
      - source/add_sub_unit.sv
      - source/logic_shift_unit.sv
      - source/result_select.sv
      - source/alu_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/tb_alu_top.sv

// File: all.f
+incdir+source
source/alu_pkg.sv
source/setter.sv
source/add_sub_unit.sv
source/logic_shift_unit.sv
source/result_select.sv
source/alu_top.sv
verification/tb_alu_top.sv

// File: source/add_sub_unit.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

module add_sub_unit (
  input  alu_pkg::alu_op_e       op,
  input  logic [`ALU_DATA_W-1:0] op_a,
  input  logic [`ALU_DATA_W-1:0] op_b,
  output logic [`ALU_DATA_W-1:0] arith_res
);

  logic [`ALU_DATA_W-1:0] sum;
  logic [`ALU_DATA_W-1:0] diff;
  logic [`ALU_DATA_W-1:0] set_res;

  assign sum  = op_a + op_b;
  // compares all work on a - b
  assign diff = op_a - op_b;

  // setter only needs the difference and both operand signs
  setter i_setter (
    .add_res (diff),
    .a_msb   (op_a[`ALU_DATA_W-1]),
    .b_msb   (op_b[`ALU_DATA_W-1]),
    .op      (op),
    .res     (set_res)
  );

  always_comb begin
    case (op)
      alu_pkg::ADD: arith_res = sum;
      alu_pkg::SEQ,
      alu_pkg::SNE,
      alu_pkg::SLE,
      alu_pkg::SGT,
      alu_pkg::SGE,
      alu_pkg::SLT: arith_res = set_res;
      // sub and anything the result stage ignores
      default:      arith_res = diff;
    endcase
  end

endmodule

// File: source/alu_macros.svh
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// operand and result width
`define ALU_DATA_W 32

// result FIFO entries
// upstream also starts with this many operation credits
`define ALU_FIFO_DEPTH 4

// credit and occupancy counters
// must hold the value ALU_FIFO_DEPTH itself
`define ALU_CRED_W 3

`endif

// File: source/alu_pkg.sv
package alu_pkg;

  // operation code seen at the ALU input
  typedef enum logic [3:0] {
    ADD = 4'd0,
    SUB = 4'd1,
    AND = 4'd2,
    OR  = 4'd3,
    XOR = 4'd4,
    NOR = 4'd5,
    SLL = 4'd6,
    SRL = 4'd7,
    SRA = 4'd8,
    // signed compares give a 0/1 word
    SEQ = 4'd9,
    SNE = 4'd10,
    SLE = 4'd11,
    SGT = 4'd12,
    SGE = 4'd13,
    SLT = 4'd14
  } alu_op_e;

  // compare kind inside the setter
  // sne, sgt and slt reuse these with the inverse flag
  typedef enum logic [1:0] {
    EQ = 2'b00,
    LE = 2'b01,
    GE = 2'b10
  } set_ctrl_e;

endpackage

// File: source/alu_top.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

module alu_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   op_valid,
  input  alu_pkg::alu_op_e       op,
  input  logic [`ALU_DATA_W-1:0] op_a,
  input  logic [`ALU_DATA_W-1:0] op_b,
  output logic                   op_credit,
  output logic                   res_valid,
  output logic [`ALU_DATA_W-1:0] res,
  input  logic                   res_credit
);

  logic [`ALU_DATA_W-1:0] arith_res;
  logic [`ALU_DATA_W-1:0] logic_res;

  // both datapaths evaluate every op in parallel
  add_sub_unit i_add_sub_unit (
    .op        (op),
    .op_a      (op_a),
    .op_b      (op_b),
    .arith_res (arith_res)
  );

  logic_shift_unit i_logic_shift_unit (
    .op        (op),
    .op_a      (op_a),
    .op_b      (op_b),
    .logic_res (logic_res)
  );

  // choice, buffering and both credit loops
  result_select i_result_select (
    .clk        (clk),
    .rst_n      (rst_n),
    .op_valid   (op_valid),
    .op         (op),
    .arith_res  (arith_res),
    .logic_res  (logic_res),
    .op_credit  (op_credit),
    .res_valid  (res_valid),
    .res        (res),
    .res_credit (res_credit)
  );

endmodule

// File: source/logic_shift_unit.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

module logic_shift_unit (
  input  alu_pkg::alu_op_e       op,
  input  logic [`ALU_DATA_W-1:0] op_a,
  input  logic [`ALU_DATA_W-1:0] op_b,
  output logic [`ALU_DATA_W-1:0] logic_res
);

  // shift amount from the low five bits of b
  logic [4:0] shamt;

  assign shamt = op_b[4:0];

  always_comb begin
    case (op)
      // bitwise group
      alu_pkg::AND: begin
        logic_res = op_a & op_b;
      end
      alu_pkg::OR: begin
        logic_res = op_a | op_b;
      end
      alu_pkg::XOR: begin
        logic_res = op_a ^ op_b;
      end
      alu_pkg::NOR: begin
        logic_res = ~(op_a | op_b);
      end
      // shift group
      alu_pkg::SLL: begin
        logic_res = op_a << shamt;
      end
      alu_pkg::SRL: begin
        logic_res = op_a >> shamt;
      end
      alu_pkg::SRA: begin
        // arithmetic shift copies the sign of a into the top
        logic_res = $signed(op_a) >>> shamt;
      end
      // arithmetic and compare ops are handled elsewhere
      default: begin
        logic_res = '0;
      end
    endcase
  end

endmodule

// File: source/result_select.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

module result_select (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   op_valid,
  input  alu_pkg::alu_op_e       op,
  input  logic [`ALU_DATA_W-1:0] arith_res,
  input  logic [`ALU_DATA_W-1:0] logic_res,
  output logic                   op_credit,
  output logic                   res_valid,
  output logic [`ALU_DATA_W-1:0] res,
  input  logic                   res_credit
);

  localparam int unsigned DEPTH = `ALU_FIFO_DEPTH;
  localparam int unsigned CW    = `ALU_CRED_W;
  localparam int unsigned PW    = $clog2(DEPTH);

  logic [`ALU_DATA_W-1:0] sel_res;
  logic [`ALU_DATA_W-1:0] fifo_mem [DEPTH];
  logic [PW-1:0]          wr_ptr;
  logic [PW-1:0]          rd_ptr;
  // entries currently held
  logic [CW-1:0]          fifo_cnt;
  // result credits granted by downstream and not yet used
  logic [CW-1:0]          res_cred;
  logic                   push;
  logic                   pop;

  // adder path owns add, sub and the compares
  always_comb begin
    case (op)
      alu_pkg::ADD,
      alu_pkg::SUB,
      alu_pkg::SEQ,
      alu_pkg::SNE,
      alu_pkg::SLE,
      alu_pkg::SGT,
      alu_pkg::SGE,
      alu_pkg::SLT: sel_res = arith_res;
      default:      sel_res = logic_res;
    endcase
  end

  // upstream only issues with a credit in hand
  // so a valid op always finds a free slot
  assign push = op_valid;
  // send one result per cycle while both an entry and a credit exist
  assign pop  = (fifo_cnt != '0) && (res_cred != '0);

  assign res_valid = pop;
  // freed slot goes straight back upstream
  assign op_credit = pop;
  assign res       = fifo_mem[rd_ptr];

  // payload storage
  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= sel_res;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
      res_cred <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + PW'(1);
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + PW'(1);
      end
      // push and pop in one cycle leave the count alone
      fifo_cnt <= fifo_cnt + CW'(push) - CW'(pop);
      // a grant and a send in the same cycle cancel out
      res_cred <= res_cred + CW'(res_credit) - CW'(pop);
    end
  end

  // upstream broke the credit loop if it issues into a full FIFO
  a_no_push_when_full : assert property (
    @(posedge clk) disable iff (!rst_n)
    op_valid |-> (fifo_cnt != CW'(DEPTH))
  ) else $error("operation issued with no credit, FIFO full");

  // downstream never grants more than it can hold
  a_res_cred_bound : assert property (
    @(posedge clk) disable iff (!rst_n)
    res_cred <= CW'(DEPTH)
  ) else $error("result credit counter above FIFO depth");

endmodule

// File: source/setter.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

module setter (
  input  logic [`ALU_DATA_W-1:0] add_res,
  input  logic                   a_msb,
  input  logic                   b_msb,
  input  alu_pkg::alu_op_e       op,
  output logic [`ALU_DATA_W-1:0] res
);

  alu_pkg::set_ctrl_e ctrl;
  logic               inverse_set;
  // flag vector is {le, ge, eq}
  logic [2:0]         flags;
  logic [2:0]         flags_sel;
  logic               set_bit;

  // map the compare op onto a kind plus inverse flag
  always_comb begin
    ctrl        = alu_pkg::EQ;
    inverse_set = 1'b0;
    case (op)
      alu_pkg::SEQ: ctrl = alu_pkg::EQ;
      alu_pkg::SLE: ctrl = alu_pkg::LE;
      alu_pkg::SGE: ctrl = alu_pkg::GE;
      alu_pkg::SNE: begin
        ctrl        = alu_pkg::EQ;
        inverse_set = 1'b1;
      end
      alu_pkg::SGT: begin
        ctrl        = alu_pkg::LE;
        inverse_set = 1'b1;
      end
      alu_pkg::SLT: begin
        ctrl        = alu_pkg::GE;
        inverse_set = 1'b1;
      end
      default: begin
        ctrl        = alu_pkg::EQ;
        inverse_set = 1'b0;
      end
    endcase
  end

  always_comb begin
    // zero difference means equal so all three hold
    if (add_res == '0) begin
      flags = 3'b111;
    end else if (add_res[`ALU_DATA_W-1]) begin
      flags = 3'b100;
    end else begin
      flags = 3'b010;
    end
    // differing signs may overflow the subtraction
    // so the operand signs decide instead of the difference
    if (a_msb != b_msb) begin
      flags = b_msb ? 3'b010 : 3'b100;
    end
  end

  // sne, sgt, slt are the complements
  assign flags_sel = inverse_set ? ~flags : flags;

  always_comb begin
    case (ctrl)
      alu_pkg::EQ: set_bit = flags_sel[0];
      alu_pkg::LE: set_bit = flags_sel[2];
      alu_pkg::GE: set_bit = flags_sel[1];
      default:     set_bit = 1'b0;
    endcase
  end

  // zero-extend to the full data word
  assign res = {{(`ALU_DATA_W-1){1'b0}}, set_bit};

endmodule

// File: verification/tb_alu_top.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

module tb_alu_top;

  logic                   clk;
  logic                   rst_n;
  logic                   op_valid;
  alu_pkg::alu_op_e       op;
  logic [`ALU_DATA_W-1:0] op_a;
  logic [`ALU_DATA_W-1:0] op_b;
  logic                   op_credit;
  logic                   res_valid;
  logic [`ALU_DATA_W-1:0] res;
  logic                   res_credit;

  // expected results in issue order
  logic [`ALU_DATA_W-1:0] expq [$];
  logic [31:0]            lfsr_state = 32'd73243;
  // credit bookkeeping on both sides
  int issued = 0;
  int returned = 0;
  int granted = 0;
  int received = 0;
  // grant policy
  // 0 grants nothing
  // 1 grants only for pending results
  // 2 keeps up to FIFO depth outstanding
  int grant_mode = 0;
  logic one_grant = 1'b0;
  int err_count = 0;
  int pass_tests = 0;
  int fail_tests = 0;
  int cycles = 0;

  alu_top i_alu_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .op_valid   (op_valid),
    .op         (op),
    .op_a       (op_a),
    .op_b       (op_b),
    .op_credit  (op_credit),
    .res_valid  (res_valid),
    .res        (res),
    .res_credit (res_credit)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  // expected result straight from the operation rules
  function automatic logic [`ALU_DATA_W-1:0] alu_ref(input alu_pkg::alu_op_e o,
      input logic [`ALU_DATA_W-1:0] a, input logic [`ALU_DATA_W-1:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (o)
      alu_pkg::ADD: return a + b;
      alu_pkg::SUB: return a - b;
      alu_pkg::AND: return a & b;
      alu_pkg::OR:  return a | b;
      alu_pkg::XOR: return a ^ b;
      alu_pkg::NOR: return ~(a | b);
      alu_pkg::SLL: return a << sh;
      alu_pkg::SRL: return a >> sh;
      alu_pkg::SRA: return $signed(a) >>> sh;
      // compares are signed and give a single bit
      alu_pkg::SEQ: return a == b;
      alu_pkg::SNE: return a != b;
      alu_pkg::SLE: return $signed(a) <= $signed(b);
      alu_pkg::SGT: return $signed(a) > $signed(b);
      alu_pkg::SGE: return $signed(a) >= $signed(b);
      alu_pkg::SLT: return $signed(a) < $signed(b);
      default:      return '0;
    endcase
  endfunction

  // called just after a rising edge and waits for an operation credit
  task automatic issue_op(input alu_pkg::alu_op_e o, input logic [`ALU_DATA_W-1:0] a,
      input logic [`ALU_DATA_W-1:0] b);
    while (`ALU_FIFO_DEPTH + returned - issued <= 0) begin
      @(posedge clk);
      #1;
    end
    op_valid = 1'b1;
    op = o;
    op_a = a;
    op_b = b;
    expq.push_back(alu_ref(o, a, b));
    issued++;
    @(posedge clk);
    #1;
    op_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (expq.size() != 0) begin
      @(posedge clk);
    end
    repeat (3) @(posedge clk);
    #1;
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      pass_tests++;
      $display("[%0t] %s: ok", $time, name);
    end else begin
      fail_tests++;
      $display("[%0t] %s: %0d errors", $time, name, err_count - errs_before);
    end
  endtask

  // downstream model that never holds more than the FIFO depth outstanding
  always @(posedge clk) begin
    #1;
    res_credit = 1'b0;
    if (rst_n && (one_grant ||
        (grant_mode == 2 && granted - received < `ALU_FIFO_DEPTH) ||
        (grant_mode == 1 && granted - received < expq.size()))) begin
      res_credit = 1'b1;
      granted++;
      one_grant = 1'b0;
    end
  end

  // scoreboard samples at the edge where registered outputs are settled
  always @(posedge clk) begin
    if (rst_n) begin
      if (op_credit !== res_valid) begin
        $display("** Error at %0t: op_credit %b does not follow res_valid %b",
                 $time, op_credit, res_valid);
        err_count++;
      end
      if (op_credit === 1'b1) begin
        returned++;
      end
      if (res_valid === 1'b1) begin
        received++;
        if (expq.size() == 0) begin
          $display("[%0t] a result arrived with nothing issued", $time);
          err_count++;
        end else if (res !== expq[0]) begin
          $display("** Error at %0t: res expected %h actual %h", $time, expq[0], res);
          err_count++;
          void'(expq.pop_front());
        end else begin
          void'(expq.pop_front());
        end
      end
    end
  end

  // about 500 operations at one or two cycles each plus drains fit well inside
  always @(posedge clk) begin
    cycles++;
    if (cycles >= 4000) begin
      $display("timeout: the run did not finish within 4000 cycles");
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    int                     errs0;
    int                     rx0;
    int                     rc0;
    logic [`ALU_DATA_W-1:0] a;
    logic [`ALU_DATA_W-1:0] b;
    alu_pkg::alu_op_e       o;
    logic [`ALU_DATA_W-1:0] ca [6] = '{32'h0000_1234, 32'h7fff_ffff, 32'h8000_0000,
                                       32'h8000_0000, 32'h7fff_ffff, 32'h0000_0000};
    logic [`ALU_DATA_W-1:0] cb [6] = '{32'h0000_1234, 32'h8000_0000, 32'h7fff_ffff,
                                       32'h0000_0001, 32'hffff_ffff, 32'h0000_0000};
    rst_n = 1'b0;
    op_valid = 1'b0;
    op = alu_pkg::ADD;
    op_a = '0;
    op_b = '0;
    res_credit = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // grants alone must not produce output after reset
    errs0 = err_count;
    grant_mode = 2;
    repeat (12) begin
      @(posedge clk);
      #1;
      if (res_valid !== 1'b0 || op_credit !== 1'b0) begin
        $display("[%0t] output pulse after reset with no operation issued", $time);
        err_count++;
      end
    end
    grant_mode = 1;
    end_test("reset state", errs0);

    errs0 = err_count;
    for (int i = 0; i < 200; i++) begin
      issue_op(rand_bits(1) ? alu_pkg::SUB : alu_pkg::ADD, rand_bits(32), rand_bits(32));
    end
    wait_drain();
    end_test("arithmetic", errs0);

    errs0 = err_count;
    for (int i = 0; i < 200; i++) begin
      a = rand_bits(32);
      b = rand_bits(32);
      o = alu_pkg::alu_op_e'(4'(2 + rand_bits(3) % 7));
      // both shift extremes appear on every shift kind
      if (i % 10 < 2) begin
        o = alu_pkg::alu_op_e'(4'(6 + (i / 10) % 3));
        b[4:0] = (i % 10 == 0) ? 5'd0 : 5'd31;
      end
      issue_op(o, a, b);
    end
    wait_drain();
    end_test("logic and shifts", errs0);

    errs0 = err_count;
    // corner pairs cover equal, max against min, overflowing differences and zero
    for (int p = 0; p < 6; p++) begin
      for (int k = 0; k < 6; k++) begin
        issue_op(alu_pkg::alu_op_e'(4'(9 + k)), ca[p], cb[p]);
      end
    end
    for (int i = 0; i < 60; i++) begin
      issue_op(alu_pkg::alu_op_e'(4'(9 + rand_bits(3) % 6)), rand_bits(32), rand_bits(32));
    end
    wait_drain();
    end_test("compares", errs0);

    errs0 = err_count;
    grant_mode = 0;
    if (granted != received) begin
      $display("[%0t] result credits still outstanding before back-pressure", $time);
      err_count++;
    end
    rx0 = received;
    for (int i = 0; i < `ALU_FIFO_DEPTH; i++) begin
      issue_op(alu_pkg::ADD, rand_bits(32), rand_bits(32));
    end
    if (`ALU_FIFO_DEPTH + returned - issued != 0) begin
      $display("[%0t] upstream still holds credits after filling the FIFO", $time);
      err_count++;
    end
    repeat (10) @(posedge clk);
    #1;
    if (received != rx0) begin
      $display("[%0t] a result left while no result credit was granted", $time);
      err_count++;
    end
    // one grant must release exactly one result and one operation credit
    for (int i = 0; i < `ALU_FIFO_DEPTH; i++) begin
      rx0 = received;
      rc0 = returned;
      one_grant = 1'b1;
      repeat (5) @(posedge clk);
      #1;
      if (received != rx0 + 1 || returned != rc0 + 1) begin
        $display("[%0t] one credit gave %0d results and %0d operation credits",
                 $time, received - rx0, returned - rc0);
        err_count++;
      end
    end
    end_test("back-pressure", errs0);

    $display("tests passed: %0d, tests failed: %0d", pass_tests, fail_tests);
    if (fail_tests == 0 && err_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
